// ==== alu.sv ====
// Combinational integer ALU, no flags and no exceptions
// Add and subtract wrap modulo 2^32; opcodes outside the list give zero

`timescale 1ns/1ps

module alu (
  input  tiny_exec_pkg::alu_op_e         op,
  input  logic [tiny_exec_pkg::XLEN-1:0] a,
  input  logic [tiny_exec_pkg::XLEN-1:0] b,
  output logic [tiny_exec_pkg::XLEN-1:0] value
);

  // Shift amount, low 5 bits of b
  logic [4:0] shamt;

  assign shamt = b[4:0];

  // -----------------------------------------------
  // Operation select
  // -----------------------------------------------

  always_comb begin
    case (op)
      tiny_exec_pkg::OP_ADD: begin
        value = a + b;
      end
      tiny_exec_pkg::OP_SUB: begin
        value = a - b;
      end
      tiny_exec_pkg::OP_AND: begin
        value = a & b;
      end
      tiny_exec_pkg::OP_OR: begin
        value = a | b;
      end
      tiny_exec_pkg::OP_XOR: begin
        value = a ^ b;
      end
      tiny_exec_pkg::OP_SLL: begin
        value = a << shamt;
      end
      tiny_exec_pkg::OP_SRL: begin
        value = a >> shamt;
      end
      // Arithmetic shift keeps the sign bit
      tiny_exec_pkg::OP_SRA: begin
        value = $signed(a) >>> shamt;
      end
      // Compares give 1 or 0
      tiny_exec_pkg::OP_SLT: begin
        value = {{(tiny_exec_pkg::XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
      end
      tiny_exec_pkg::OP_SLTU: begin
        value = {{(tiny_exec_pkg::XLEN-1){1'b0}}, (a < b)};
      end
      // Immediate to upper half, lower half cleared
      tiny_exec_pkg::OP_LUI: begin
        value = {b[15:0], 16'h0000};
      end
      default: begin
        value = '0;
      end
    endcase
  end

endmodule

// ==== operand_fetch.sv ====
// Operand fetch and execute-stage pipeline register
// Forwards the result in execute to a dependent instruction on the next cycle
// No stall: an instruction is accepted on every cycle that in_valid is high

`timescale 1ns/1ps

module operand_fetch #(
  parameter int NUM_REGS = 32
) (
  input  logic                             clk,
  input  logic                             reset,

  // Decoded instruction strobe
  input  logic                             in_valid,
  input  tiny_exec_pkg::exec_instr_t       in_instr,

  // Register file read data, combinational
  input  logic [tiny_exec_pkg::XLEN-1:0]   rd_data0,
  input  logic [tiny_exec_pkg::XLEN-1:0]   rd_data1,

  // Result of the instruction now in execute
  input  logic [tiny_exec_pkg::XLEN-1:0]   alu_value,

  output logic [tiny_exec_pkg::REG_AW-1:0] rd_addr0,
  output logic [tiny_exec_pkg::REG_AW-1:0] rd_addr1,

  // Execute stage
  output logic                             e_valid,
  output tiny_exec_pkg::alu_op_e           e_op,
  output logic [tiny_exec_pkg::REG_AW-1:0] e_rd,
  output logic [tiny_exec_pkg::XLEN-1:0]   e_a,
  output logic [tiny_exec_pkg::XLEN-1:0]   e_b
);

  logic                           fwd_a;
  logic                           fwd_b;
  logic [tiny_exec_pkg::XLEN-1:0] imm_ext;
  logic [tiny_exec_pkg::XLEN-1:0] op_a;
  logic [tiny_exec_pkg::XLEN-1:0] op_b;

  // Source addresses straight from the incoming instruction
  assign rd_addr0 = in_instr.rs1;
  assign rd_addr1 = in_instr.rs2;

  // -----------------------------------------------
  // Bypass from execute
  // -----------------------------------------------

  // Register 0 is never forwarded, it must keep reading zero
  assign fwd_a = e_valid && (in_instr.rs1 == e_rd) && (in_instr.rs1 != '0);
  assign fwd_b = e_valid && (in_instr.rs2 == e_rd) && (in_instr.rs2 != '0);

  // Immediate, sign-extended to the word width
  assign imm_ext = {{(tiny_exec_pkg::XLEN-16){in_instr.imm[15]}}, in_instr.imm};

  // Operand select
  assign op_a = fwd_a ? alu_value : rd_data0;

  always_comb begin
    if (in_instr.use_imm) begin
      op_b = imm_ext;
    end else if (fwd_b) begin
      op_b = alu_value;
    end else begin
      op_b = rd_data1;
    end
  end

  // -----------------------------------------------
  // Execute-stage register
  // -----------------------------------------------

  // Valid bit
  always_ff @(posedge clk) begin
    if (reset) begin
      e_valid <= 1'b0;
    end else begin
      e_valid <= in_valid;
    end
  end

  // Payload, only loaded with a new instruction
  always_ff @(posedge clk) begin
    if (in_valid) begin
      e_op <= in_instr.op;
      e_rd <= in_instr.rd;
      e_a  <= op_a;
      e_b  <= op_b;
    end
  end

  // -----------------------------------------------
  // Checks
  // -----------------------------------------------

  // Decoder must only name registers that exist in this build
  a_in_addr_range: assert property (
    @(posedge clk) disable iff (reset)
      in_valid |-> ((in_instr.rs1 < NUM_REGS) && (in_instr.rs2 < NUM_REGS) &&
                    (in_instr.rd < NUM_REGS))
  ) else $error("instruction names a register at or above %0d", NUM_REGS);

endmodule

// ==== regfile_2r1w_zero.sv ====
// Two combinational read ports and one write port, register 0 always reads zero
// All entries clear on reset; a write shows on the read ports after the next edge
// Addresses at or above NUM_REGS are illegal

`timescale 1ns/1ps

module regfile_2r1w_zero #(
  parameter int NUM_REGS = 32
) (
  input  logic                             clk,
  input  logic                             reset,

  // Read ports, combinational
  input  logic [tiny_exec_pkg::REG_AW-1:0] rd_addr0,
  input  logic [tiny_exec_pkg::REG_AW-1:0] rd_addr1,

  // Write port, sampled on the rising edge
  input  logic                             wr_en,
  input  logic [tiny_exec_pkg::REG_AW-1:0] wr_addr,
  input  logic [tiny_exec_pkg::XLEN-1:0]   wr_data,

  output logic [tiny_exec_pkg::XLEN-1:0]   rd_data0,
  output logic [tiny_exec_pkg::XLEN-1:0]   rd_data1
);

  // Register storage
  logic [tiny_exec_pkg::XLEN-1:0] regs [NUM_REGS];

  // -----------------------------------------------
  // Write port
  // -----------------------------------------------

  // Entry 0 is never written so it stays at its reset value
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // -----------------------------------------------
  // Read ports
  // -----------------------------------------------

  // Address zero forced to zero on both ports
  always_comb begin
    rd_data0 = regs[rd_addr0];
    if (rd_addr0 == '0) begin
      rd_data0 = '0;
    end
  end

  always_comb begin
    rd_data1 = regs[rd_addr1];
    if (rd_addr1 == '0) begin
      rd_data1 = '0;
    end
  end

  // -----------------------------------------------
  // Checks
  // -----------------------------------------------

  // Write-back from the execute stage must target an existing register
  a_wr_addr_range: assert property (
    @(posedge clk) disable iff (reset)
      wr_en |-> (wr_addr < NUM_REGS)
  ) else $error("regfile write to register %0d, only %0d exist", wr_addr, NUM_REGS);

endmodule

// ==== tiny_exec.f ====
tiny_exec_pkg.sv
regfile_2r1w_zero.sv
operand_fetch.sv
alu.sv
tiny_exec.sv
tiny_exec_tb.sv

// ==== tiny_exec.sv ====
// Integer execute core with operand fetch, one ALU stage, write-back and result strobe
// Fixed latency of one cycle from the edge that samples in_valid to out_valid
// No back-pressure so out_result must be taken in the cycle it appears

`timescale 1ns/1ps

module tiny_exec #(
  parameter int NUM_REGS = 32
) (
  input  logic                        clk,
  input  logic                        reset,

  // Decoded instruction strobe
  input  logic                        in_valid,
  input  tiny_exec_pkg::exec_instr_t  in_instr,

  // Result strobe
  output logic                        out_valid,
  output tiny_exec_pkg::exec_result_t out_result
);

  // Register file read path
  logic [tiny_exec_pkg::REG_AW-1:0] rd_addr0;
  logic [tiny_exec_pkg::REG_AW-1:0] rd_addr1;
  logic [tiny_exec_pkg::XLEN-1:0]   rd_data0;
  logic [tiny_exec_pkg::XLEN-1:0]   rd_data1;

  // Execute stage
  logic                             e_valid;
  tiny_exec_pkg::alu_op_e           e_op;
  logic [tiny_exec_pkg::REG_AW-1:0] e_rd;
  logic [tiny_exec_pkg::XLEN-1:0]   e_a;
  logic [tiny_exec_pkg::XLEN-1:0]   e_b;
  logic [tiny_exec_pkg::XLEN-1:0]   alu_value;

  // -----------------------------------------------
  // Datapath
  // -----------------------------------------------

  operand_fetch #(.NUM_REGS(NUM_REGS)) i_operand_fetch (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_instr  (in_instr),
    .rd_data0  (rd_data0),
    .rd_data1  (rd_data1),
    .alu_value (alu_value),
    .rd_addr0  (rd_addr0),
    .rd_addr1  (rd_addr1),
    .e_valid   (e_valid),
    .e_op      (e_op),
    .e_rd      (e_rd),
    .e_a       (e_a),
    .e_b       (e_b)
  );

  alu i_alu (
    .op    (e_op),
    .a     (e_a),
    .b     (e_b),
    .value (alu_value)
  );

  // Write-back at the edge that ends the execute cycle
  regfile_2r1w_zero #(.NUM_REGS(NUM_REGS)) i_regfile (
    .clk      (clk),
    .reset    (reset),
    .rd_addr0 (rd_addr0),
    .rd_addr1 (rd_addr1),
    .wr_en    (e_valid),
    .wr_addr  (e_rd),
    .wr_data  (alu_value),
    .rd_data0 (rd_data0),
    .rd_data1 (rd_data1)
  );

  // -----------------------------------------------
  // Result register
  // -----------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= e_valid;
    end
  end

  // Writes to register 0 still report the computed value
  always_ff @(posedge clk) begin
    if (e_valid) begin
      out_result.rd    <= e_rd;
      out_result.value <= alu_value;
    end
  end

endmodule

// ==== tiny_exec_pkg.sv ====
// Shared types for the tiny_exec integer core
// Word width is fixed at 32 bits and register addresses at 5 bits
// The ALU opcode encoding is private to this core and not a standard ISA encoding

package tiny_exec_pkg;

  // -----------------------------------------------
  // Widths
  // -----------------------------------------------

  // Data word width
  parameter int XLEN = 32;

  // Register address width, enough for 32 architectural registers
  parameter int REG_AW = 5;

  // -----------------------------------------------
  // ALU opcodes
  // -----------------------------------------------

  // Shifts take the low 5 bits of operand b
  // LUI puts the 16-bit immediate in the upper half
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLL  = 4'd5,
    OP_SRL  = 4'd6,
    OP_SRA  = 4'd7,
    OP_SLT  = 4'd8,
    OP_SLTU = 4'd9,
    OP_LUI  = 4'd10
  } alu_op_e;

  // -----------------------------------------------
  // Instruction and result records
  // -----------------------------------------------

  // One decoded instruction from the upstream decoder
  typedef struct packed {
    alu_op_e           op;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic              use_imm;   // Operand b from imm instead of rs2
    logic [15:0]       imm;       // Sign-extended when used as operand b
  } exec_instr_t;

  // One completed result, as written back
  typedef struct packed {
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   value;
  } exec_result_t;

endpackage

// ==== tiny_exec_tb.sv ====
// Directed testbench for tiny_exec with an in-order reference model
// Inputs change on the falling edge; outputs are checked on the falling edge

`timescale 1ns/1ps

module tiny_exec_tb;

  logic                        clk;
  logic                        reset;
  logic                        in_valid;
  tiny_exec_pkg::exec_instr_t  in_instr;
  logic                        out_valid;
  tiny_exec_pkg::exec_result_t out_result;

  // Reference register state and expected results in issue order
  logic [tiny_exec_pkg::XLEN-1:0] model_regs [32];
  tiny_exec_pkg::exec_result_t    exp_q [$];
  tiny_exec_pkg::exec_result_t    exp_r;

  // Issue history, bit 1 is the edge whose result is due now
  logic [1:0] issued_d;
  logic       monitor_on;

  tiny_exec #(.NUM_REGS(32)) i_tiny_exec (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_instr   (in_instr),
    .out_valid  (out_valid),
    .out_result (out_result)
  );

  // 40 ns clock
  always #20 clk = ~clk;

  // --------------------------------------------------
  // Error reporting and typed compares
  // --------------------------------------------------

  task automatic report_error(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_error($sformatf("FAIL at %0t: %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  // Destination and value checked on their own
  task automatic compare_result(input string name, input tiny_exec_pkg::exec_result_t exp,
                                input tiny_exec_pkg::exec_result_t act);
    if (act.rd !== exp.rd) begin
      report_error($sformatf("FAIL at %0t: %s.rd expected %0d got %0d",
                             $time, name, exp.rd, act.rd));
    end
    if (act.value !== exp.value) begin
      report_error($sformatf("FAIL at %0t: %s.value expected %h got %h",
                             $time, name, exp.value, act.value));
    end
  endtask

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  function automatic logic [31:0] model_alu(input tiny_exec_pkg::alu_op_e op,
                                            input logic [31:0] a, input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      tiny_exec_pkg::OP_ADD:  return a + b;
      tiny_exec_pkg::OP_SUB:  return a + ~b + 32'd1;
      tiny_exec_pkg::OP_AND:  return a & b;
      tiny_exec_pkg::OP_OR:   return a | b;
      tiny_exec_pkg::OP_XOR:  return a ^ b;
      tiny_exec_pkg::OP_SLL:  return a << sh;
      tiny_exec_pkg::OP_SRL:  return a >> sh;
      // Fill the vacated upper bits with the sign
      tiny_exec_pkg::OP_SRA:  return (a >> sh) | (a[31] ? ~(32'hffffffff >> sh) : 32'd0);
      // Differing signs decide on the sign bit alone
      tiny_exec_pkg::OP_SLT:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
      tiny_exec_pkg::OP_SLTU: return {31'd0, a < b};
      tiny_exec_pkg::OP_LUI:  return {b[15:0], 16'd0};
      default:                return 32'd0;
    endcase
  endfunction

  // --------------------------------------------------
  // Drive tasks
  // --------------------------------------------------

  // Model applies the instruction now, DUT samples it on the next rising edge
  task automatic issue(input tiny_exec_pkg::alu_op_e op, input logic [4:0] rd,
                       input logic [4:0] rs1, input logic [4:0] rs2,
                       input logic use_imm, input logic [15:0] imm);
    tiny_exec_pkg::exec_instr_t  instr;
    tiny_exec_pkg::exec_result_t res;
    logic [31:0]                 a;
    logic [31:0]                 b;
    instr.op = op;
    instr.rd = rd;
    instr.rs1 = rs1;
    instr.rs2 = rs2;
    instr.use_imm = use_imm;
    instr.imm = imm;
    a = model_regs[rs1];
    b = use_imm ? {{16{imm[15]}}, imm} : model_regs[rs2];
    res.rd = rd;
    res.value = model_alu(op, a, b);
    if (rd != 5'd0) begin
      model_regs[rd] = res.value;
    end
    exp_q.push_back(res);
    @(negedge clk);
    in_valid = 1'b1;
    in_instr = instr;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  // Stop issuing and wait for every expected result
  task automatic wait_results();
    int waited;
    idle(1);
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited == 20) begin
        report_error("timed out waiting for out_valid, results still outstanding");
      end
      @(posedge clk);
      waited++;
    end
  endtask

  // --------------------------------------------------
  // Result monitor
  // --------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      issued_d <= 2'b00;
    end else begin
      issued_d <= {issued_d[0], in_valid};
    end
  end

  // out_valid must follow each issue edge by exactly one cycle
  always @(negedge clk) begin
    if (monitor_on) begin
      compare_bit("out_valid", issued_d[1], out_valid);
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          report_error("result strobe seen with no instruction outstanding");
        end
        exp_r = exp_q.pop_front();
        compare_result("out_result", exp_r, out_result);
      end
    end
  end

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------

  task automatic test_reset();
    reset = 1'b1;
    repeat (10) begin
      @(negedge clk);
      compare_bit("out_valid", 1'b0, out_valid);
    end
    reset = 1'b0;
    monitor_on = 1'b1;
    idle(5);
    // Every register reads zero after reset
    for (int r = 0; r < 32; r++) begin
      issue(tiny_exec_pkg::OP_OR, 5'd0, 5'(r), 5'd0, 1'b0, 16'd0);
    end
    wait_results();
  endtask

  task automatic test_opcodes();
    // Operands r1..r4
    issue(tiny_exec_pkg::OP_LUI, 5'd1, 5'd0, 5'd0, 1'b1, 16'h7fff);
    issue(tiny_exec_pkg::OP_OR,  5'd1, 5'd1, 5'd0, 1'b1, 16'h7fff);
    issue(tiny_exec_pkg::OP_LUI, 5'd2, 5'd0, 5'd0, 1'b1, 16'h8000);
    issue(tiny_exec_pkg::OP_OR,  5'd3, 5'd0, 5'd0, 1'b1, 16'hffff);
    issue(tiny_exec_pkg::OP_OR,  5'd4, 5'd0, 5'd0, 1'b1, 16'h0005);
    idle(2);
    // Add overflow both ways
    issue(tiny_exec_pkg::OP_ADD,  5'd5, 5'd1, 5'd1, 1'b0, 16'd0);
    issue(tiny_exec_pkg::OP_ADD,  5'd5, 5'd2, 5'd2, 1'b0, 16'd0);
    issue(tiny_exec_pkg::OP_SUB,  5'd6, 5'd2, 5'd4, 1'b0, 16'd0);
    issue(tiny_exec_pkg::OP_AND,  5'd7, 5'd1, 5'd2, 1'b0, 16'd0);
    issue(tiny_exec_pkg::OP_OR,   5'd7, 5'd1, 5'd2, 1'b0, 16'd0);
    issue(tiny_exec_pkg::OP_XOR,  5'd7, 5'd1, 5'd3, 1'b0, 16'd0);
    issue(tiny_exec_pkg::OP_SLL,  5'd8, 5'd3, 5'd4, 1'b0, 16'd0);
    // Logical against arithmetic right shift of a negative word
    issue(tiny_exec_pkg::OP_SRL,  5'd8, 5'd2, 5'd4, 1'b0, 16'd0);
    issue(tiny_exec_pkg::OP_SRA,  5'd8, 5'd2, 5'd4, 1'b0, 16'd0);
    issue(tiny_exec_pkg::OP_SRA,  5'd8, 5'd1, 5'd0, 1'b1, 16'h003f);
    // Signed against unsigned compare
    issue(tiny_exec_pkg::OP_SLT,  5'd9, 5'd2, 5'd4, 1'b0, 16'd0);
    issue(tiny_exec_pkg::OP_SLTU, 5'd9, 5'd2, 5'd4, 1'b0, 16'd0);
    issue(tiny_exec_pkg::OP_SLT,  5'd9, 5'd4, 5'd3, 1'b0, 16'd0);
    issue(tiny_exec_pkg::OP_SLTU, 5'd9, 5'd4, 5'd3, 1'b0, 16'd0);
    issue(tiny_exec_pkg::OP_LUI,  5'd9, 5'd0, 5'd0, 1'b1, 16'h1234);
    wait_results();
  endtask

  task automatic test_reg_zero();
    // Reported value is the sum, a following read of r0 still gives zero
    issue(tiny_exec_pkg::OP_ADD, 5'd0, 5'd4, 5'd0, 1'b1, 16'h0007);
    issue(tiny_exec_pkg::OP_ADD, 5'd10, 5'd0, 5'd4, 1'b0, 16'd0);
    idle(2);
    issue(tiny_exec_pkg::OP_OR,  5'd10, 5'd0, 5'd0, 1'b0, 16'd0);
    wait_results();
  endtask

  task automatic test_bypass();
    issue(tiny_exec_pkg::OP_ADD, 5'd11, 5'd4, 5'd0, 1'b1, 16'h0003);
    issue(tiny_exec_pkg::OP_ADD, 5'd12, 5'd11, 5'd0, 1'b1, 16'h0001);
    issue(tiny_exec_pkg::OP_SUB, 5'd13, 5'd4, 5'd12, 1'b0, 16'd0);
    issue(tiny_exec_pkg::OP_ADD, 5'd13, 5'd13, 5'd13, 1'b0, 16'd0);
    issue(tiny_exec_pkg::OP_XOR, 5'd14, 5'd13, 5'd12, 1'b0, 16'd0);
    wait_results();
  endtask

  task automatic test_random_burst();
    for (int i = 0; i < 50; i++) begin
      issue(tiny_exec_pkg::alu_op_e'($urandom_range(0, 10)), 5'($urandom),
            5'($urandom), 5'($urandom), 1'($urandom), 16'($urandom));
      if ($urandom_range(0, 2) == 0) begin
        idle($urandom_range(1, 3));
      end
    end
    wait_results();
  endtask

  // --------------------------------------------------
  // Run
  // --------------------------------------------------

  initial begin
    void'($urandom(32'hf89dcde7));
    clk = 1'b0;
    reset = 1'b1;
    in_valid = 1'b0;
    in_instr = '0;
    monitor_on = 1'b0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    test_reset();
    test_opcodes();
    test_reg_zero();
    test_bypass();
    test_random_burst();
    idle(3);
    $display("sim passed");
    $finish;
  end

endmodule
